// File: cdc_fifo_pkg.sv
package cdc_fifo_pkg;

  // geometry of the clock domain crossing fifo
  // the depth is always a power of two so that the index wraps for free
  localparam int unsigned LogDepth = 3;

  // number of payload registers in the storage
  localparam int unsigned Depth = 1 << LogDepth;

  // pointers carry one extra wrap bit above the entry index
  localparam int unsigned PtrWidth = LogDepth + 1;

  // a fifo pointer, with the entry index in the low bits and the wrap bit on top
  typedef logic [PtrWidth-1:0] ptr_t;

  // an entry index into the register storage
  typedef logic [LogDepth-1:0] idx_t;

  // the xor of write and read pointer equals this pattern when the fifo is full
  // which means the wrap bits differ while the index bits agree
  localparam ptr_t PtrFull = ptr_t'(1 << LogDepth);

  // the xor of write and read pointer is zero when the fifo is empty
  localparam ptr_t PtrEmpty = '0;

endpackage

// File: cdc_payload_pkg.sv
package cdc_payload_pkg;

  // width of one payload word moved through the fifo
  localparam int unsigned DataWidth = 32;

  // one payload word as pushed on the source side and popped on the destination side
  typedef logic [DataWidth-1:0] data_t;

endpackage

// File: cdc_2phase_src.sv
`timescale 1ns/10ps

module cdc_2phase_src (
  input  logic               src_clk_i,
  input  logic               src_rst_ni,
  input  cdc_fifo_pkg::ptr_t data_i,
  input  logic               async_ack_i,
  output logic               async_req_o,
  output cdc_fifo_pkg::ptr_t async_data_o
);

  // ack arrives from the other clock domain and goes through two flops first
  logic ack_q1;
  logic ack_q2;

  // request phase, toggled once per launched pointer
  logic req_q;

  // high while no transfer is in flight
  logic idle;

  // two flop synchronizer for the acknowledge
  // the first flop may go metastable, the second one settles it
  always_ff @(posedge src_clk_i or negedge src_rst_ni) begin
    if (!src_rst_ni) begin
      ack_q1 <= 1'b0;
      ack_q2 <= 1'b0;
    end else begin
      ack_q1 <= async_ack_i;
      ack_q2 <= ack_q1;
    end
  end

  // the capture side has answered the last request once both phases agree
  assign idle = (ack_q2 == req_q);

  // launch the present pointer and flip the request in the same cycle
  // the launched pointer then holds still until the ack comes back, so the
  // capture side never samples it while it changes
  always_ff @(posedge src_clk_i or negedge src_rst_ni) begin
    if (!src_rst_ni) begin
      req_q        <= 1'b0;
      async_data_o <= '0;
    end else if (idle) begin
      req_q        <= ~req_q;
      async_data_o <= data_i;
    end
  end

  // the request leaves the module straight from its flop
  assign async_req_o = req_q;

endmodule

// File: cdc_2phase_dst.sv
`timescale 1ns/10ps

module cdc_2phase_dst (
  input  logic               dst_clk_i,
  input  logic               dst_rst_ni,
  input  logic               async_req_i,
  input  cdc_fifo_pkg::ptr_t async_data_i,
  output logic               async_ack_o,
  output cdc_fifo_pkg::ptr_t data_o
);

  // request from the launch side, brought in through two flops
  logic req_q1;
  logic req_q2;

  // acknowledge phase, it also remembers the last request phase seen
  logic ack_q;

  // high for one cycle when a new request phase has been seen
  logic capture;

  // two flop synchronizer for the request
  always_ff @(posedge dst_clk_i or negedge dst_rst_ni) begin
    if (!dst_rst_ni) begin
      req_q1 <= 1'b0;
      req_q2 <= 1'b0;
    end else begin
      req_q1 <= async_req_i;
      req_q2 <= req_q1;
    end
  end

  // a new transfer is pending whenever the synchronized request differs from ack
  // since ack follows req this doubles as the edge detector
  assign capture = (req_q2 != ack_q);

  // copy the launched pointer and answer by flipping ack
  // the pointer has been stable since req toggled, two flop stages earlier
  always_ff @(posedge dst_clk_i or negedge dst_rst_ni) begin
    if (!dst_rst_ni) begin
      ack_q  <= 1'b0;
      data_o <= '0;
    end else if (capture) begin
      ack_q  <= ~ack_q;
      data_o <= async_data_i;
    end
  end

  // the ack goes back to the launch side directly from its flop
  assign async_ack_o = ack_q;

  // output pointer changes three destination cycles after the request toggles

endmodule

// File: cdc_fifo_2phase.sv
`timescale 1ns/10ps

module cdc_fifo_2phase (
  input  logic                   src_clk_i,
  input  logic                   src_rst_ni,
  input  logic                   dst_clk_i,
  input  logic                   dst_rst_ni,
  input  cdc_payload_pkg::data_t src_data_i,
  input  logic                   src_valid_i,
  output logic                   src_ready_o,
  output cdc_payload_pkg::data_t dst_data_o,
  output logic                   dst_valid_o,
  input  logic                   dst_ready_i
);

  import cdc_fifo_pkg::*;
  import cdc_payload_pkg::*;

  // both resets must be asserted together and released in their own domain
  // otherwise one side may see a stale pointer from the other side

  // register storage, written in the source domain and read without a clock
  data_t fifo_data_q [Depth];

  // write pointer owned by the source domain and its copy in the destination domain
  ptr_t src_wptr_q;
  ptr_t dst_wptr;

  // read pointer owned by the destination domain and its copy in the source domain
  ptr_t dst_rptr_q;
  ptr_t src_rptr;

  // entry index for the write and for the read port
  idx_t wr_idx;
  idx_t rd_idx;

  // a word moves when valid and ready are both high on a clock edge
  logic push;
  logic pop;

  // wires between the launch and capture sides of the write pointer crossing
  logic wptr_async_req;
  logic wptr_async_ack;
  ptr_t wptr_async_data;

  // wires between the launch and capture sides of the read pointer crossing
  logic rptr_async_req;
  logic rptr_async_ack;
  ptr_t rptr_async_data;

  assign push = src_valid_i && src_ready_o;
  assign pop  = dst_valid_o && dst_ready_i;

  // the low pointer bits select the entry, the wrap bit is left out
  assign wr_idx = src_wptr_q[LogDepth-1:0];
  assign rd_idx = dst_rptr_q[LogDepth-1:0];

  // one register per entry, only the addressed one loads on a push
  for (genvar i = 0; i < Depth; i++) begin : g_word
    always_ff @(posedge src_clk_i or negedge src_rst_ni) begin
      if (!src_rst_ni) begin
        fifo_data_q[i] <= '0;
      end else if (push && (wr_idx == idx_t'(i))) begin
        fifo_data_q[i] <= src_data_i;
      end
    end
  end

  // the head word is presented as soon as the read pointer points at it
  assign dst_data_o = fifo_data_q[rd_idx];

  // write pointer advances once per accepted word
  always_ff @(posedge src_clk_i or negedge src_rst_ni) begin
    if (!src_rst_ni) begin
      src_wptr_q <= '0;
    end else if (push) begin
      src_wptr_q <= src_wptr_q + 1'b1;
    end
  end

  // read pointer advances once per popped word
  always_ff @(posedge dst_clk_i or negedge dst_rst_ni) begin
    if (!dst_rst_ni) begin
      dst_rptr_q <= '0;
    end else if (pop) begin
      dst_rptr_q <= dst_rptr_q + 1'b1;
    end
  end

  // full when only the wrap bits differ, empty when the pointers agree
  // the crossed pointers lag behind, so both flags err on the safe side
  assign src_ready_o = ((src_wptr_q ^ src_rptr) != PtrFull);
  assign dst_valid_o = ((dst_rptr_q ^ dst_wptr) != PtrEmpty);

  // write pointer crossing from the source into the destination domain
  cdc_2phase_src u_wptr_src (
    .src_clk_i    (src_clk_i),
    .src_rst_ni   (src_rst_ni),
    .data_i       (src_wptr_q),
    .async_ack_i  (wptr_async_ack),
    .async_req_o  (wptr_async_req),
    .async_data_o (wptr_async_data)
  );

  cdc_2phase_dst u_wptr_dst (
    .dst_clk_i    (dst_clk_i),
    .dst_rst_ni   (dst_rst_ni),
    .async_req_i  (wptr_async_req),
    .async_data_i (wptr_async_data),
    .async_ack_o  (wptr_async_ack),
    .data_o       (dst_wptr)
  );

  // read pointer crossing, here the destination clock drives the launch side
  cdc_2phase_src u_rptr_src (
    .src_clk_i    (dst_clk_i),
    .src_rst_ni   (dst_rst_ni),
    .data_i       (dst_rptr_q),
    .async_ack_i  (rptr_async_ack),
    .async_req_o  (rptr_async_req),
    .async_data_o (rptr_async_data)
  );

  cdc_2phase_dst u_rptr_dst (
    .dst_clk_i    (src_clk_i),
    .dst_rst_ni   (src_rst_ni),
    .async_req_i  (rptr_async_req),
    .async_data_i (rptr_async_data),
    .async_ack_o  (rptr_async_ack),
    .data_o       (src_rptr)
  );

endmodule

// File: tb_cdc_fifo_2phase.sv
`timescale 1ns/10ps

module tb_cdc_fifo_2phase;

  import cdc_fifo_pkg::*;
  import cdc_payload_pkg::*;

  // clock periods in ns, the destination clock is the slower one
  localparam int SrcPeriod = 40;
  localparam int DstPeriod = 56;

  // cycles that src_ready_o must stay low once the fifo is full
  localparam int HoldCycles = 40;
  localparam int RandWords  = 200;

  // every word or wait cycle of all tests gets Margin slow clock periods
  localparam int Margin    = 20;
  localparam int TimeoutNs =
    (2 + Depth + HoldCycles + Depth + RandWords + 1) * DstPeriod * Margin;

  logic  src_clk_i;
  logic  src_rst_ni;
  logic  dst_clk_i;
  logic  dst_rst_ni;
  data_t src_data_i;
  logic  src_valid_i;
  logic  src_ready_o;
  data_t dst_data_o;
  logic  dst_valid_o;
  logic  dst_ready_i;

  // words accepted on the push port and words taken from the pop port
  int push_count = 0;
  int pop_count  = 0;

  // the compare process keeps its own error count
  int errors       = 0;
  int pop_errors   = 0;
  int errors_mark  = 0;
  int tests_run    = 0;
  int tests_failed = 0;

  // one seed per domain, so coincident edges never race for the generator
  int seed = 32'hd2594ad0;
  int src_seed;
  int dst_seed;
  int pop_target;

  cdc_fifo_2phase u_dut (
    .src_clk_i   (src_clk_i),
    .src_rst_ni  (src_rst_ni),
    .dst_clk_i   (dst_clk_i),
    .dst_rst_ni  (dst_rst_ni),
    .src_data_i  (src_data_i),
    .src_valid_i (src_valid_i),
    .src_ready_o (src_ready_o),
    .dst_data_o  (dst_data_o),
    .dst_valid_o (dst_valid_o),
    .dst_ready_i (dst_ready_i)
  );

  initial begin
    src_clk_i = 1'b0;
    forever #(SrcPeriod / 2) src_clk_i = ~src_clk_i;
  end

  initial begin
    dst_clk_i = 1'b0;
    forever #(DstPeriod / 2) dst_clk_i = ~dst_clk_i;
  end

  // payload of the n-th pushed word, a multiplicative hash with n in the low half
  function automatic data_t ref_word(input int n);
    return (data_t'(n) * 32'h9e37_79b9) ^ {16'ha5c3, 16'(n)};
  endfunction

  task automatic check_value(input string name, input int got, input int exp);
    assert (got == exp) else begin
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    int total;
    total = errors + pop_errors;
    tests_run++;
    if (total > errors_mark) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, total - errors_mark);
    end else begin
      $display("test %s: passed", name);
    end
    errors_mark = total;
  endtask

  // random valid, but a word once offered stays offered until it is taken
  task automatic drive_source(input int count);
    int target;
    int draw;
    int offered;
    target  = push_count + count;
    offered = -1;
    @(negedge src_clk_i);
    while (push_count < target) begin
      if (!src_valid_i || push_count != offered) begin
        draw        = $random(src_seed);
        src_valid_i = draw[0];
        offered     = push_count;
      end
      src_data_i = ref_word(push_count);
      @(negedge src_clk_i);
    end
    src_valid_i = 1'b0;
  endtask

  task automatic drive_sink(input int target);
    int draw;
    @(negedge dst_clk_i);
    while (pop_count < target) begin
      draw        = $random(dst_seed);
      dst_ready_i = draw[0];
      @(negedge dst_clk_i);
    end
    dst_ready_i = 1'b0;
  endtask

  // count accepted pushes, nonblocking so other processes see the old count
  always @(posedge src_clk_i) begin
    if (src_rst_ni && src_valid_i && src_ready_o) begin
      push_count <= push_count + 1;
    end
  end

  // every popped word must be the next one in push order
  always @(posedge dst_clk_i) begin
    if (dst_rst_ni && dst_valid_o && dst_ready_i) begin
      assert (pop_count < push_count) else begin
        $display("error at %0t: a word was popped that was never pushed", $time);
        pop_errors++;
      end
      assert (dst_data_o == ref_word(pop_count)) else begin
        $display("mismatch at %0t: dst_data_o got %h expected %h",
                 $time, dst_data_o, ref_word(pop_count));
        pop_errors++;
      end
      pop_count <= pop_count + 1;
    end
  end

  initial begin
    #(TimeoutNs);
    $display("timeout: the tests did not finish within %0d ns", TimeoutNs);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    src_rst_ni  = 1'b0;
    dst_rst_ni  = 1'b0;
    src_data_i  = '0;
    src_valid_i = 1'b0;
    dst_ready_i = 1'b0;
    src_seed    = seed;
    dst_seed    = seed + 1;

    // both resets go low together, each is released on its own falling edge
    repeat (2) @(posedge src_clk_i);
    fork
      begin
        @(negedge src_clk_i);
        src_rst_ni = 1'b1;
      end
      begin
        @(negedge dst_clk_i);
        dst_rst_ni = 1'b1;
      end
    join

    @(negedge src_clk_i);
    check_value("dst_valid_o", int'(dst_valid_o), 0);
    check_value("src_ready_o", int'(src_ready_o), 1);
    end_test("reset_state");

    // nothing is popped, so the fifo takes Depth words and then blocks
    src_valid_i = 1'b1;
    while (push_count < Depth) begin
      src_data_i = ref_word(push_count);
      @(negedge src_clk_i);
    end
    src_data_i = ref_word(push_count);
    repeat (HoldCycles) begin
      check_value("src_ready_o", int'(src_ready_o), 0);
      @(negedge src_clk_i);
    end
    src_valid_i = 1'b0;
    check_value("push_count", push_count, Depth);
    end_test("fill_to_full");

    // drain, then both flags must settle to the empty state
    // ready stays high until both sides show empty, so a stray word would be popped
    @(negedge dst_clk_i);
    dst_ready_i = 1'b1;
    while (pop_count < Depth) @(negedge dst_clk_i);
    while (dst_valid_o) @(negedge dst_clk_i);
    while (!src_ready_o) @(negedge src_clk_i);
    @(negedge dst_clk_i);
    dst_ready_i = 1'b0;
    check_value("pop_count", pop_count, Depth);
    end_test("drain_in_order");

    pop_target = push_count + RandWords;
    fork
      drive_source(RandWords);
      drive_sink(pop_target);
    join
    // every pushed word has been popped, so the fifo must show empty
    check_value("dst_valid_o", int'(dst_valid_o), 0);
    end_test("random_traffic");

    // one word into the empty fifo, seen at the pop port, then empty again
    @(negedge src_clk_i);
    pop_target  = push_count + 1;
    src_data_i  = ref_word(push_count);
    src_valid_i = 1'b1;
    while (push_count < pop_target) @(negedge src_clk_i);
    src_valid_i = 1'b0;
    while (!dst_valid_o) @(negedge dst_clk_i);
    assert (dst_data_o == ref_word(pop_count)) else begin
      $display("mismatch at %0t: dst_data_o got %h expected %h",
               $time, dst_data_o, ref_word(pop_count));
      errors++;
    end
    dst_ready_i = 1'b1;
    while (pop_count < pop_target) @(negedge dst_clk_i);
    while (dst_valid_o) @(negedge dst_clk_i);
    while (!src_ready_o) @(negedge src_clk_i);
    @(negedge dst_clk_i);
    dst_ready_i = 1'b0;
    check_value("pop_count", pop_count, pop_target);
    end_test("single_word");

    $display("summary: %0d tests run, %0d failed, %0d errors, %0d pushed, %0d popped",
             tests_run, tests_failed, errors + pop_errors, push_count, pop_count);
    if (errors + pop_errors == 0 && tests_failed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: compile.f
cdc_fifo_pkg.sv
cdc_payload_pkg.sv
cdc_2phase_src.sv
cdc_2phase_dst.sv
cdc_fifo_2phase.sv
tb_cdc_fifo_2phase.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cdc fifo testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f compile.f \
  --top-module tb_cdc_fifo_2phase \
  --Mdir obj_dir \
  -o tb_cdc_fifo_2phase

./obj_dir/tb_cdc_fifo_2phase > sim.log 2>&1
cat sim.log

# the log decides the result
if grep -q "Some tests failed" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "All tests passed" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
